// File: source/pcie_bus_pkg.sv
`default_nettype none

package pcie_bus_pkg;

    // bytes carried by one beat of the write port
    localparam int BEAT_BYTES = 64;

    // longest burst the host bridge accepts
    localparam int MAX_BURST = 8;

    // payload word repeated through the body of each generated flit
    localparam logic [63:0] FILL_PATTERN = 64'h0000babe0000face;

    // one packet beat as it travels through the packet FIFO
    typedef struct packed {
        logic [511:0] data;
        logic         sop;
        logic         eop;
    } flit_t;

    // bus-master write request
    typedef struct packed {
        logic         write;
        logic [63:0]  address;
        logic [63:0]  byteenable;
        logic [511:0] writedata;
        // nonzero only on the first beat of a burst
        logic [3:0]   burstcount;
    } bas_wr_t;

endpackage

`default_nettype wire

// File: source/ring_pkg.sv
`default_nettype none

package ring_pkg;

    localparam int QUEUE_IDX_W = 6;

    // ring pointers count flits
    localparam int RB_PTR_W = 20;

    typedef logic [QUEUE_IDX_W-1:0] queue_idx_t;
    typedef logic [RB_PTR_W-1:0]    rb_ptr_t;

    localparam int DWORDS_PER_FLIT = 16;

    // each queue owns one host page, the first beat of it holds the tail pointer
    localparam int QUEUE_PAGE_BYTES = 4096;

    typedef struct packed {
        queue_idx_t  queue_id;
        // in flits
        logic [16:0] size;
    } pkt_desc_t;

    typedef struct packed {
        rb_ptr_t     head;
        rb_ptr_t     tail;
        logic [63:0] kmem_addr;
    } queue_state_t;

endpackage

`default_nettype wire

// File: source/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// show-ahead FIFO, the head entry is always presented on rd_data
module sync_fifo #(
    parameter int DEPTH = 512,
    parameter int WIDTH = 32
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [WIDTH-1:0]         wr_data,
    input  wire                     wr_en,
    output logic [WIDTH-1:0]        rd_data,
    input  wire                     rd_en,
    output logic [$clog2(DEPTH):0]  occup
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    assign rd_data = mem[rd_ptr];

    // storage only, the pointers below decide what is valid
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occup  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   occup <= occup + 1'b1;
                2'b01:   occup <= occup - 1'b1;
                default: occup <= occup;
            endcase
        end
    end

    // producers must respect the occupancy they are given
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (occup != ($clog2(DEPTH) + 1)'(DEPTH)));

    // a consumer only pops an entry that is already shown at the head
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> (occup != '0));

endmodule

`default_nettype wire

// File: source/request_gen.sv
`timescale 1ns/1ps
`default_nettype none

module request_gen #(
    parameter int FIFO_DEPTH = 512
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire [31:0]                   target_nb_requests,
    // in dwords
    input  wire [31:0]                   req_size,
    input  wire [30:0]                   rb_size,
    input  wire [$clog2(FIFO_DEPTH):0]   pkt_occup,
    input  wire [$clog2(FIFO_DEPTH):0]   desc_occup,
    output pcie_bus_pkg::flit_t          flit,
    output logic                         flit_wr_en,
    output ring_pkg::pkt_desc_t          desc,
    output logic                         desc_wr_en,
    output logic [31:0]                  transmit_cycles,
    output logic [31:0]                  max_occupancy
);

    localparam int OCC_W = $clog2(FIFO_DEPTH) + 1;

    typedef enum logic {
        GEN_IDLE,
        GEN_DATA
    } gen_state_t;

    gen_state_t           state;
    ring_pkg::queue_idx_t queue_id;
    logic [31:0]          nb_requests;
    logic [31:0]          flits_written;
    logic [31:0]          last_target;
    logic [31:0]          req_flits;
    logic [63:0]          next_queue_end;
    logic                 can_insert;
    logic                 last_flit;

    assign req_flits = (req_size + 32'(ring_pkg::DWORDS_PER_FLIT - 1))
                       / 32'(ring_pkg::DWORDS_PER_FLIT);
    assign last_flit = (flits_written + 32'd1) >= req_flits;

    // keep a little headroom since the write lands a cycle after the check
    assign can_insert = (pkt_occup < OCC_W'(FIFO_DEPTH - 2))
                        && (desc_occup < OCC_W'(FIFO_DEPTH - 2));

    // end of the next queue's page plus one request must fit in the host ring
    assign next_queue_end = (64'(queue_id) + 64'd1) * ring_pkg::QUEUE_PAGE_BYTES
                            + 64'(req_size) * 4;

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= GEN_IDLE;
            flit_wr_en      <= 1'b0;
            desc_wr_en      <= 1'b0;
            queue_id        <= '0;
            nb_requests     <= '0;
            flits_written   <= '0;
            last_target     <= '0;
            transmit_cycles <= '0;
            max_occupancy   <= '0;
        end else begin
            flit_wr_en  <= 1'b0;
            desc_wr_en  <= 1'b0;
            last_target <= target_nb_requests;

            case (state)
                GEN_IDLE: begin
                    if (nb_requests < target_nb_requests) begin
                        queue_id      <= '0;
                        flits_written <= '0;
                        state         <= GEN_DATA;
                    end
                end
                GEN_DATA: begin
                    if (can_insert) begin
                        flit_wr_en    <= 1'b1;
                        flit.data     <= {nb_requests, 32'h0, {7{pcie_bus_pkg::FILL_PATTERN}}};
                        flit.sop      <= (flits_written == '0);
                        flit.eop      <= last_flit;
                        flits_written <= flits_written + 32'd1;
                        if (last_flit) begin
                            flits_written <= '0;
                            nb_requests   <= nb_requests + 32'd1;
                            desc_wr_en    <= 1'b1;
                            desc.queue_id <= queue_id;
                            desc.size     <= req_flits[16:0];
                            if (nb_requests + 32'd1 == target_nb_requests) begin
                                state <= GEN_IDLE;
                            end else if (next_queue_end > 64'(rb_size) * 64) begin
                                queue_id <= '0;
                            end else begin
                                queue_id <= queue_id + 1'b1;
                            end
                        end
                    end
                end
                default: state <= GEN_IDLE;
            endcase

            // run lasts until generation stops and the packet FIFO has drained
            if (state != GEN_IDLE || pkt_occup != '0) begin
                transmit_cycles <= transmit_cycles + 32'd1;
            end

            if (32'(pkt_occup) > max_occupancy) begin
                max_occupancy <= 32'(pkt_occup);
            end

            // new target starts a fresh run
            if (target_nb_requests != last_target) begin
                nb_requests     <= '0;
                transmit_cycles <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/dma_writer.sv
`timescale 1ns/1ps
`default_nettype none

module dma_writer #(
    parameter int FIFO_DEPTH = 512
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire pcie_bus_pkg::flit_t     pkt_head,
    input  wire [$clog2(FIFO_DEPTH):0]   pkt_occup,
    output logic                         pkt_rd_en,
    input  wire ring_pkg::pkt_desc_t     desc_head,
    input  wire [$clog2(FIFO_DEPTH):0]   desc_occup,
    output logic                         desc_rd_en,
    output ring_pkg::queue_idx_t         rd_queue,
    output logic                         queue_rd_en,
    input  wire                          queue_ready,
    input  wire ring_pkg::queue_state_t  queue_state,
    output ring_pkg::queue_idx_t         wr_queue,
    output ring_pkg::rb_ptr_t            out_tail,
    output logic                         tail_wr_en,
    input  wire [30:0]                   rb_size,
    input  wire                          write_pointer,
    output pcie_bus_pkg::bas_wr_t        bas_wr,
    input  wire                          pcie_bas_waitrequest,
    output logic [31:0]                  dma_stall_cnt
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BURST,
        ST_CONT,
        ST_DONE
    } state_t;

    state_t              state;
    ring_pkg::pkt_desc_t cur_desc;
    ring_pkg::rb_ptr_t   cur_tail;
    logic [63:0]         cur_kmem;
    logic                cur_valid;
    logic [16:0]         missing_flits;
    logic [3:0]          burst_left;
    logic [3:0]          burst_len;
    logic [63:0]         page_offset;
    logic [63:0]         beat_offset;
    logic [31:0]         tail_sum;
    ring_pkg::rb_ptr_t   new_tail;
    logic                beat_due;
    logic                beat_go;
    logic                done_go;

    // a beat can go once the queue state is known and the bridge is free
    assign beat_due = (state == ST_BURST && cur_valid) || state == ST_CONT;
    assign beat_go  = beat_due && !pcie_bas_waitrequest && (pkt_occup != '0);
    assign done_go  = (state == ST_DONE) && !pcie_bas_waitrequest;

    // pops land in the same cycle so the next beat sees the next flit
    assign pkt_rd_en  = beat_go;
    assign desc_rd_en = (state == ST_IDLE) && (desc_occup != '0);

    assign burst_len = (missing_flits > 17'(pcie_bus_pkg::MAX_BURST))
                       ? 4'(pcie_bus_pkg::MAX_BURST) : missing_flits[3:0];

    // data starts one beat into the queue page, after the tail slot
    assign page_offset = 64'(cur_desc.queue_id) * ring_pkg::QUEUE_PAGE_BYTES;
    assign beat_offset = 64'(cur_desc.size - missing_flits) * pcie_bus_pkg::BEAT_BYTES;

    assign tail_sum = 32'(cur_tail) + 32'(cur_desc.size);
    assign new_tail = (tail_sum >= 32'(rb_size)) ? ring_pkg::rb_ptr_t'(tail_sum - 32'(rb_size))
                                                 : ring_pkg::rb_ptr_t'(tail_sum);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            cur_valid     <= 1'b0;
            queue_rd_en   <= 1'b0;
            tail_wr_en    <= 1'b0;
            bas_wr.write  <= 1'b0;
            dma_stall_cnt <= '0;
        end else begin
            queue_rd_en <= 1'b0;
            tail_wr_en  <= 1'b0;

            // a pending request was taken this cycle
            if (!pcie_bas_waitrequest) begin
                bas_wr.write <= 1'b0;
            end

            if ((beat_due && !beat_go) || (state == ST_DONE && !done_go)) begin
                dma_stall_cnt <= dma_stall_cnt + 32'd1;
            end

            case (state)
                ST_IDLE: begin
                    if (desc_rd_en) begin
                        cur_desc    <= desc_head;
                        rd_queue    <= desc_head.queue_id;
                        queue_rd_en <= 1'b1;
                        cur_valid   <= 1'b0;
                        state       <= ST_BURST;
                    end
                end
                ST_BURST: begin
                    if (!cur_valid && queue_ready) begin
                        cur_valid     <= 1'b1;
                        cur_tail      <= queue_state.tail;
                        cur_kmem      <= queue_state.kmem_addr;
                        missing_flits <= cur_desc.size;
                    end else if (beat_go) begin
                        bas_wr.write      <= 1'b1;
                        bas_wr.address    <= cur_kmem + 64'(pcie_bus_pkg::BEAT_BYTES)
                                             + page_offset + beat_offset;
                        bas_wr.byteenable <= '1;
                        bas_wr.writedata  <= pkt_head.data;
                        bas_wr.burstcount <= burst_len;
                        missing_flits     <= missing_flits - 1'b1;
                        burst_left        <= burst_len - 1'b1;
                        state             <= (missing_flits > 17'd1) ? ST_CONT : ST_DONE;
                    end
                end
                ST_CONT: begin
                    if (beat_go) begin
                        bas_wr.write      <= 1'b1;
                        bas_wr.byteenable <= '1;
                        bas_wr.writedata  <= pkt_head.data;
                        bas_wr.burstcount <= '0;
                        missing_flits     <= missing_flits - 1'b1;
                        burst_left        <= burst_left - 1'b1;
                        if (burst_left == 4'd1) begin
                            state <= (missing_flits > 17'd1) ? ST_BURST : ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    if (done_go) begin
                        if (write_pointer) begin
                            bas_wr.write      <= 1'b1;
                            bas_wr.address    <= cur_kmem + page_offset;
                            bas_wr.byteenable <= 64'h0000_0000_0000_000f;
                            bas_wr.writedata  <= 512'(new_tail);
                            bas_wr.burstcount <= 4'd1;
                        end
                        out_tail   <= new_tail;
                        wr_queue   <= cur_desc.queue_id;
                        tail_wr_en <= 1'b1;
                        cur_valid  <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // generator framing must line up with the descriptor sizes
    a_first_beat_sop: assert property (@(posedge clk) disable iff (rst)
        (beat_go && missing_flits == cur_desc.size) |-> pkt_head.sop);

    a_last_beat_eop: assert property (@(posedge clk) disable iff (rst)
        (beat_go && missing_flits == 17'd1) |-> pkt_head.eop);

endmodule

`default_nettype wire

// File: source/fpga2cpu_dma.sv
`timescale 1ns/1ps
`default_nettype none

module fpga2cpu_dma #(
    parameter int FIFO_DEPTH = 512
) (
    input  wire                          clk,
    input  wire                          rst,
    output ring_pkg::queue_idx_t         rd_queue,
    output logic                         queue_rd_en,
    input  wire                          queue_ready,
    input  wire ring_pkg::queue_state_t  queue_state,
    output ring_pkg::queue_idx_t         wr_queue,
    output ring_pkg::rb_ptr_t            out_tail,
    output logic                         tail_wr_en,
    output pcie_bus_pkg::bas_wr_t        bas_wr,
    input  wire                          pcie_bas_waitrequest,
    input  wire [30:0]                   rb_size,
    input  wire                          write_pointer,
    input  wire [31:0]                   target_nb_requests,
    input  wire [31:0]                   req_size,
    output logic [31:0]                  dma_stall_cnt,
    output logic [31:0]                  max_occupancy,
    output logic [31:0]                  transmit_cycles
);

    pcie_bus_pkg::flit_t        pkt_wr_data;
    logic                       pkt_wr_en;
    pcie_bus_pkg::flit_t        pkt_head;
    logic                       pkt_rd_en;
    logic [$clog2(FIFO_DEPTH):0] pkt_occup;

    ring_pkg::pkt_desc_t        desc_wr_data;
    logic                       desc_wr_en;
    ring_pkg::pkt_desc_t        desc_head;
    logic                       desc_rd_en;
    logic [$clog2(FIFO_DEPTH):0] desc_occup;

    request_gen #(.FIFO_DEPTH(FIFO_DEPTH)) request_gen_i (
        .clk(clk), .rst(rst),
        .target_nb_requests(target_nb_requests), .req_size(req_size), .rb_size(rb_size),
        .pkt_occup(pkt_occup), .desc_occup(desc_occup),
        .flit(pkt_wr_data), .flit_wr_en(pkt_wr_en),
        .desc(desc_wr_data), .desc_wr_en(desc_wr_en),
        .transmit_cycles(transmit_cycles), .max_occupancy(max_occupancy)
    );

    sync_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH($bits(pcie_bus_pkg::flit_t))) pkt_fifo_i (
        .clk(clk), .rst(rst), .wr_data(pkt_wr_data), .wr_en(pkt_wr_en),
        .rd_data(pkt_head), .rd_en(pkt_rd_en), .occup(pkt_occup)
    );

    // sized like the packet FIFO to cover a run of single-flit packets
    sync_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH($bits(ring_pkg::pkt_desc_t))) desc_fifo_i (
        .clk(clk), .rst(rst), .wr_data(desc_wr_data), .wr_en(desc_wr_en),
        .rd_data(desc_head), .rd_en(desc_rd_en), .occup(desc_occup)
    );

    dma_writer #(.FIFO_DEPTH(FIFO_DEPTH)) dma_writer_i (
        .clk(clk), .rst(rst),
        .pkt_head(pkt_head), .pkt_occup(pkt_occup), .pkt_rd_en(pkt_rd_en),
        .desc_head(desc_head), .desc_occup(desc_occup), .desc_rd_en(desc_rd_en),
        .rd_queue(rd_queue), .queue_rd_en(queue_rd_en),
        .queue_ready(queue_ready), .queue_state(queue_state),
        .wr_queue(wr_queue), .out_tail(out_tail), .tail_wr_en(tail_wr_en),
        .rb_size(rb_size), .write_pointer(write_pointer),
        .bas_wr(bas_wr), .pcie_bas_waitrequest(pcie_bas_waitrequest),
        .dma_stall_cnt(dma_stall_cnt)
    );

endmodule

`default_nettype wire

// File: tests/host_model.sv
`timescale 1ns/1ps
`default_nettype none

// queue table and host bus model that checks every write and tail update
module host_model (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          new_run,
    input  wire [31:0]                   req_size,
    input  wire [30:0]                   rb_size,
    input  wire                          write_pointer,
    input  wire ring_pkg::queue_idx_t    rd_queue,
    input  wire                          queue_rd_en,
    output ring_pkg::queue_state_t       queue_state = '0,
    output logic                         queue_ready = 1'b0,
    input  wire ring_pkg::queue_idx_t    wr_queue,
    input  wire ring_pkg::rb_ptr_t       out_tail,
    input  wire                          tail_wr_en,
    input  wire pcie_bus_pkg::bas_wr_t   bas_wr,
    output logic                         waitrequest = 1'b0,
    output logic [31:0]                  packets_done = '0,
    output logic                         busy = 1'b0,
    output logic                         mismatch = 1'b0
);

    localparam int NB_QUEUES = 1 << ring_pkg::QUEUE_IDX_W;

    integer                seed = 32'h338c;
    logic [63:0]           kmem [NB_QUEUES];
    ring_pkg::rb_ptr_t     table_tail [NB_QUEUES];
    ring_pkg::rb_ptr_t     exp_tail [NB_QUEUES];
    logic                  pend;
    logic [2:0]            ready_delay;
    ring_pkg::queue_idx_t  pend_queue;
    logic [31:0]           exp_req;
    logic [31:0]           beat_idx;
    logic [31:0]           tail_count;
    ring_pkg::queue_idx_t  beat_queue;
    ring_pkg::queue_idx_t  tail_queue;
    logic                  ptr_due;
    ring_pkg::rb_ptr_t     ptr_tail;
    pcie_bus_pkg::bas_wr_t held;
    logic                  held_valid;
    pcie_bus_pkg::bas_wr_t exp_wr;
    logic [31:0]           nb_flits;

    assign nb_flits = (req_size + 32'd15) / 32'd16;

    initial begin
        for (int q = 0; q < NB_QUEUES; q++) begin
            kmem[q]       = {32'($random(seed)), 32'($random(seed))} & ~64'hfff;
            table_tail[q] = ring_pkg::rb_ptr_t'(32'($random(seed)) & 32'h7f);
            exp_tail[q]   = table_tail[q];
        end
    end

    // round robin, back to 0 once the next page plus a request leaves the ring
    function automatic ring_pkg::queue_idx_t next_queue(input ring_pkg::queue_idx_t q);
        logic [63:0] page_end;
        page_end = (64'(q) + 64'd1) * 64'd4096 + 64'(req_size) * 64'd4;
        if (page_end > 64'(rb_size) * 64'd64) begin
            return '0;
        end
        return q + ring_pkg::queue_idx_t'(1);
    endfunction

    function automatic ring_pkg::rb_ptr_t next_tail(input ring_pkg::queue_idx_t q);
        logic [31:0] sum;
        sum = 32'(exp_tail[q]) + nb_flits;
        if (sum >= 32'(rb_size)) begin
            sum = sum - 32'(rb_size);
        end
        return ring_pkg::rb_ptr_t'(sum);
    endfunction

    // expected request for beat k of a packet, or its pointer write
    function automatic pcie_bus_pkg::bas_wr_t expected_write(input ring_pkg::queue_idx_t q,
            input logic [31:0] req, input logic [31:0] k, input logic pointer,
            input ring_pkg::rb_ptr_t tail);
        pcie_bus_pkg::bas_wr_t b;
        logic [31:0] left;
        left    = nb_flits - k;
        b.write = 1'b1;
        if (pointer) begin
            b.address    = kmem[q] + 64'(q) * 64'd4096;
            b.byteenable = 64'hf;
            b.writedata  = 512'(tail);
            b.burstcount = 4'd1;
        end else begin
            b.address    = kmem[q] + 64'd64 + 64'(q) * 64'd4096 + 64'(k) * 64'd64;
            b.byteenable = '1;
            b.writedata  = {req, 32'h0, {7{pcie_bus_pkg::FILL_PATTERN}}};
            b.burstcount = (k % 32'd8 != 0) ? 4'd0 : (left > 32'd8) ? 4'd8 : left[3:0];
        end
        return b;
    endfunction

    task automatic check_bas(input string name, input pcie_bus_pkg::bas_wr_t got,
            input pcie_bus_pkg::bas_wr_t exp, input logic check_addr);
        if (!check_addr) begin
            exp.address = got.address;
        end
        if (got !== exp) begin
            $display("FAILED %s write: got %h expected %h", name, got.write, exp.write);
            $display("FAILED %s address: got %h expected %h", name, got.address, exp.address);
            $display("FAILED %s byteenable: got %h expected %h", name, got.byteenable,
                     exp.byteenable);
            $display("FAILED %s writedata: got %h", name, got.writedata);
            $display("FAILED %s writedata: expected %h", name, exp.writedata);
            $display("FAILED %s burstcount: got %h expected %h", name, got.burstcount,
                     exp.burstcount);
            mismatch = 1'b1;
        end
    endtask

    task automatic check_tail(input ring_pkg::queue_idx_t got_q, input ring_pkg::queue_idx_t exp_q,
            input ring_pkg::rb_ptr_t got_t, input ring_pkg::rb_ptr_t exp_t);
        if (got_q !== exp_q || got_t !== exp_t) begin
            $display("FAILED wr_queue/out_tail: got %h/%h expected %h/%h",
                     got_q, got_t, exp_q, exp_t);
            mismatch = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            waitrequest <= 1'b0;
            queue_ready <= 1'b0;
            pend        = 1'b0;
            held_valid  = 1'b0;
            exp_req     = '0;
            beat_idx    = '0;
            tail_count  = '0;
            beat_queue  = '0;
            tail_queue  = '0;
            ptr_due     = 1'b0;
        end else begin
            waitrequest <= (($random(seed) & 3) == 0);
            queue_ready <= 1'b0;
            if (new_run) begin
                exp_req    = '0;
                beat_idx   = '0;
                tail_count = '0;
                beat_queue = '0;
                tail_queue = '0;
                ptr_due    = 1'b0;
            end

            // table answers 1 to 4 cycles after the read strobe
            if (queue_rd_en) begin
                pend        = 1'b1;
                pend_queue  = rd_queue;
                ready_delay = 3'($random(seed) & 3);
            end else if (pend && ready_delay == 0) begin
                queue_ready <= 1'b1;
                queue_state <= '{head: '0, tail: table_tail[pend_queue],
                                 kmem_addr: kmem[pend_queue]};
                pend = 1'b0;
            end else if (pend) begin
                ready_delay = ready_delay - 3'd1;
            end

            // a stalled request must hold every field
            if (held_valid) begin
                check_bas("held bas_wr", bas_wr, held, 1'b1);
            end
            held       = bas_wr;
            held_valid = bas_wr.write && waitrequest;

            if (bas_wr.write && !waitrequest) begin
                if (ptr_due) begin
                    exp_wr = expected_write(beat_queue, exp_req, '0, 1'b1, ptr_tail);
                    check_bas("pointer bas_wr", bas_wr, exp_wr, 1'b1);
                    ptr_due    = 1'b0;
                    exp_req    = exp_req + 32'd1;
                    beat_queue = next_queue(beat_queue);
                end else begin
                    exp_wr = expected_write(beat_queue, exp_req, beat_idx, 1'b0, '0);
                    check_bas("beat bas_wr", bas_wr, exp_wr, exp_wr.burstcount != 4'd0);
                    beat_idx = beat_idx + 32'd1;
                    if (beat_idx == nb_flits) begin
                        beat_idx = '0;
                        if (write_pointer) begin
                            ptr_due  = 1'b1;
                            ptr_tail = next_tail(beat_queue);
                        end else begin
                            exp_req    = exp_req + 32'd1;
                            beat_queue = next_queue(beat_queue);
                        end
                    end
                end
            end

            if (tail_wr_en) begin
                check_tail(wr_queue, tail_queue, out_tail, next_tail(tail_queue));
                exp_tail[tail_queue] = next_tail(tail_queue);
                table_tail[wr_queue] = out_tail;
                tail_count           = tail_count + 32'd1;
                tail_queue           = next_queue(tail_queue);
            end

            packets_done <= tail_count;
            busy         <= ptr_due || beat_idx != 0 || bas_wr.write;
        end
    end

endmodule

`default_nettype wire

// File: tests/fpga2cpu_dma_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpga2cpu_dma_tb;

    localparam int FIFO_DEPTH = 64;
    localparam int CLK_PERIOD = 40;
    // flits over the four runs below
    localparam int TOTAL_FLITS = 40 * 1 + 30 * 8 + 25 * 9 + 20 * 20;
    localparam int WATCHDOG_CYCLES = TOTAL_FLITS * 6 + 2000;
    // long enough for one more packet to reach its tail update
    localparam int QUIET_CYCLES = 200;

    logic                  clk;
    logic                  rst;
    logic                  new_run;
    logic [30:0]           rb_size;
    logic                  write_pointer;
    logic [31:0]           target_nb_requests;
    logic [31:0]           req_size;
    ring_pkg::queue_idx_t  rd_queue;
    logic                  queue_rd_en;
    logic                  queue_ready;
    ring_pkg::queue_state_t queue_state;
    ring_pkg::queue_idx_t  wr_queue;
    ring_pkg::rb_ptr_t     out_tail;
    logic                  tail_wr_en;
    pcie_bus_pkg::bas_wr_t bas_wr;
    logic                  pcie_bas_waitrequest;
    logic [31:0]           dma_stall_cnt;
    logic [31:0]           max_occupancy;
    logic [31:0]           transmit_cycles;
    logic [31:0]           packets_done;
    logic                  busy;
    logic                  mismatch;

    fpga2cpu_dma #(.FIFO_DEPTH(FIFO_DEPTH)) fpga2cpu_dma_i (
        .clk(clk), .rst(rst),
        .rd_queue(rd_queue), .queue_rd_en(queue_rd_en),
        .queue_ready(queue_ready), .queue_state(queue_state),
        .wr_queue(wr_queue), .out_tail(out_tail), .tail_wr_en(tail_wr_en),
        .bas_wr(bas_wr), .pcie_bas_waitrequest(pcie_bas_waitrequest),
        .rb_size(rb_size), .write_pointer(write_pointer),
        .target_nb_requests(target_nb_requests), .req_size(req_size),
        .dma_stall_cnt(dma_stall_cnt), .max_occupancy(max_occupancy),
        .transmit_cycles(transmit_cycles)
    );

    host_model host_i (
        .clk(clk), .rst(rst), .new_run(new_run),
        .req_size(req_size), .rb_size(rb_size), .write_pointer(write_pointer),
        .rd_queue(rd_queue), .queue_rd_en(queue_rd_en),
        .queue_state(queue_state), .queue_ready(queue_ready),
        .wr_queue(wr_queue), .out_tail(out_tail), .tail_wr_en(tail_wr_en),
        .bas_wr(bas_wr), .waitrequest(pcie_bas_waitrequest),
        .packets_done(packets_done), .busy(busy), .mismatch(mismatch)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_stat(input string name, input logic [31:0] value,
            input logic [31:0] lo, input logic [31:0] hi);
        if (value < lo || value > hi) begin
            $display("FAILED %s: got %h expected %h to %h", name, value, lo, hi);
            stop_with_failure();
        end
    endtask

    // one profiling run, done once every packet has its tail update
    task automatic run_phase(input logic [31:0] nb, input logic [31:0] size,
            input logic [30:0] rb, input logic wp);
        logic [31:0] elapsed;
        elapsed = '0;
        @(posedge clk);
        req_size           <= size;
        rb_size            <= rb;
        write_pointer      <= wp;
        target_nb_requests <= nb;
        new_run            <= 1'b1;
        @(posedge clk);
        new_run <= 1'b0;
        @(posedge clk);
        elapsed = 32'd2;
        while (packets_done < nb || busy) begin
            @(posedge clk);
            elapsed = elapsed + 32'd1;
        end
        // packets past the target would show up in this window
        repeat (QUIET_CYCLES) @(posedge clk);
        check_stat("packets_done", packets_done, nb, nb);
        // counter restarts with the run, so it cannot exceed the run length
        check_stat("transmit_cycles", transmit_cycles, 32'd1, elapsed);
        check_stat("max_occupancy", max_occupancy, 32'd1, 32'(FIFO_DEPTH));
    endtask

    initial begin
        wait (mismatch);
        stop_with_failure();
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before all runs finished");
        stop_with_failure();
    end

    initial begin
        rst                = 1'b1;
        new_run            = 1'b0;
        rb_size            = 31'd1024;
        write_pointer      = 1'b0;
        target_nb_requests = '0;
        req_size           = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // 1 flit, 16 queues then wrap
        run_phase(32'd40, 32'd16, 31'd1024, 1'b1);
        // 8 flits over two queues, tails wrap in a small ring
        run_phase(32'd30, 32'd128, 31'd128, 1'b0);
        run_phase(32'd25, 32'd144, 31'd128, 1'b1);
        run_phase(32'd20, 32'd320, 31'd1024, 1'b1);
        check_stat("dma_stall_cnt", dma_stall_cnt, 32'd1, 32'hffff_ffff);

        repeat (4) @(posedge clk);
        if (!mismatch) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: tb.f
source/pcie_bus_pkg.sv
source/ring_pkg.sv
source/sync_fifo.sv
source/request_gen.sv
source/dma_writer.sv
source/fpga2cpu_dma.sv
tests/host_model.sv
tests/fpga2cpu_dma_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the DMA profiler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module fpga2cpu_dma_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
